// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -sv -f verilog.f \
		--top-module bev_monitor_tb -Mdir obj_dir -o bev_monitor_sim

run: compile
	@out="$$(./obj_dir/bev_monitor_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: common/bev_mon_pkg.sv
// Beverage monitor shared types
package bev_mon_pkg;

    // Number of box_sup steps in one supply operation
    localparam int SUPPLY_BOXES = 4;

    // Free running cycle stamp, wraps after 65535 cycles
    typedef logic [15:0] stamp_t;
    typedef logic [3:0] month_t;
    typedef logic [4:0] day_t;
    typedef logic [$clog2(SUPPLY_BOXES + 1) - 1:0] box_cnt_t;

    // Encodings follow the machine interface
    typedef enum logic [1:0] {
        make_drink = 2'd0,
        supply     = 2'd1,
        check_date = 2'd2
    } action_t;

    typedef enum logic [1:0] {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2,
        ing_of = 2'd3
    } err_t;

    // Which input strobe was seen in a cycle
    typedef enum logic [2:0] {
        step_none,
        step_sel_action,
        step_bev_type,
        step_bev_size,
        step_date,
        step_box_no,
        step_box_sup
    } step_t;

    // Violation codes, a lower code wins when two collide
    typedef enum logic [3:0] {
        rule_overlap  = 4'd0,
        rule_order    = 4'd1,
        rule_gap      = 4'd2,
        rule_date     = 4'd3,
        rule_latency  = 4'd4,
        rule_pulse    = 4'd5,
        rule_complete = 4'd6,
        rule_bridge   = 4'd7
    } rule_t;

    // February always has 28 days, an unknown month has none
    function automatic day_t days_in_month(input month_t m);
        case (m)
            4'd2: return day_t'(28);
            4'd4, 4'd6, 4'd9, 4'd11: return day_t'(30);
            4'd1, 4'd3, 4'd5, 4'd7, 4'd8, 4'd10, 4'd12: return day_t'(31);
            default: return day_t'(0);
        endcase
    endfunction

endpackage

// File: common/mon_event_if.sv
// Captured event bus
`timescale 1ns/1ps

interface mon_event_if import bev_mon_pkg::*;;

    // Decoded step of this cycle, none when no strobe or several strobes
    step_t   step;
    action_t act;
    logic    multi;
    logic    date_ok;
    // Edge number at which these values were sampled
    stamp_t  stamp;
    logic    out_valid;
    logic    complete;
    err_t    err;
    logic    c_in;
    logic    c_out;

    modport capture (
        output step, act, multi, date_ok, stamp,
        output out_valid, complete, err, c_in, c_out
    );

    modport seq (input step, act, multi, date_ok, stamp);

    modport response (input stamp, out_valid, complete, err, c_in, c_out);

endinterface

// File: report/report_sender.sv
// Violation report sender
`timescale 1ns/1ps

module report_sender import bev_mon_pkg::*; #(
    parameter int REPORT_DEPTH   = 4,
    parameter int REPORT_CREDITS = 2
) (
    input  logic   clk,
    input  logic   inf,
    input  logic   seq_viol,
    input  rule_t  seq_rule,
    input  stamp_t seq_stamp,
    input  logic   rsp_viol,
    input  rule_t  rsp_rule,
    input  stamp_t rsp_stamp,
    input  logic   credit_return,
    output logic   report_valid,
    output rule_t  report_rule,
    output stamp_t report_stamp,
    output logic   report_lost
);

    localparam int PW   = $clog2(REPORT_DEPTH);
    localparam int CNTW = $clog2(REPORT_DEPTH + 1);
    // One spare bit so an extra returned credit stays visible to the check below
    localparam int CW   = $clog2(REPORT_CREDITS + 1) + 1;

    rule_t           rule_mem  [REPORT_DEPTH];
    stamp_t          stamp_mem [REPORT_DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CNTW-1:0] count;
    logic [CW-1:0]   credits;
    logic            any_viol;
    logic            take_seq;
    logic            full;
    logic            push;
    logic            issue;
    rule_t           in_rule;
    stamp_t          in_stamp;

    // When both checkers fire, the lower rule code is kept
    assign any_viol = seq_viol || rsp_viol;
    assign take_seq = seq_viol && (!rsp_viol || seq_rule <= rsp_rule);
    assign in_rule  = take_seq ? seq_rule : rsp_rule;
    assign in_stamp = take_seq ? seq_stamp : rsp_stamp;
    assign full     = count == CNTW'(REPORT_DEPTH);
    assign push     = any_viol && !full;
    assign issue    = (count != '0) && (credits != '0);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credits      <= CW'(REPORT_CREDITS);
            report_valid <= 1'b0;
            report_lost  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(REPORT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= (rd_ptr == PW'(REPORT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + CNTW'(push) - CNTW'(issue);
            credits      <= credits - CW'(issue) + CW'(credit_return);
            report_valid <= issue;
            // Sticky until reset, set by a collision or by a full queue
            report_lost  <= report_lost || (seq_viol && rsp_viol) || (any_viol && full);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            rule_mem[wr_ptr]  <= in_rule;
            stamp_mem[wr_ptr] <= in_stamp;
        end
        if (issue) begin
            report_rule  <= rule_mem[rd_ptr];
            report_stamp <= stamp_mem[rd_ptr];
        end
    end

    // The receiver can never give back more than it was granted
    a_credit_max: assert property (@(posedge clk) disable iff (!inf)
        credits <= CW'(REPORT_CREDITS));

endmodule

// File: rule_check/response_check.sv
// Response and bridge checker
`timescale 1ns/1ps

module response_check import bev_mon_pkg::*; #(
    parameter int LATENCY_MAX = 1000
) (
    input  logic   clk,
    input  logic   inf,
    input  logic   op_done,
    mon_event_if.response ev,
    output logic   rsp_viol,
    output rule_t  rsp_rule,
    output stamp_t rsp_stamp
);

    localparam int LW = $clog2(LATENCY_MAX + 1);

    logic          pending;
    logic [LW-1:0] lat_cnt;
    logic          out_q;
    logic          busy;
    logic          lat_hit;
    logic          viol_d;
    rule_t         rule_d;

    // op_done lines up with the event one cycle after the last step,
    // so lat_cnt+1 cycles have passed since that step
    assign lat_hit = pending && !op_done && !ev.out_valid &&
                     (lat_cnt == LW'(LATENCY_MAX));

    always_comb begin
        viol_d = 1'b1;
        rule_d = rule_latency;
        if (lat_hit) begin
            rule_d = rule_latency;
        end else if (ev.out_valid && out_q) begin
            rule_d = rule_pulse;
        end else if (ev.complete && ev.err != no_err) begin
            rule_d = rule_complete;
        // busy covers a c_in that lasts two cycles as well as a repeat before c_out
        end else if (ev.c_in && busy) begin
            rule_d = rule_bridge;
        end else begin
            viol_d = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            pending  <= 1'b0;
            lat_cnt  <= '0;
            out_q    <= 1'b0;
            busy     <= 1'b0;
            rsp_viol <= 1'b0;
        end else begin
            rsp_viol <= viol_d;
            out_q    <= ev.out_valid;
            if (ev.c_in) begin
                busy <= 1'b1;
            end else if (ev.c_out) begin
                busy <= 1'b0;
            end
            // A new operation restarts the timer, the deadline reports only once
            if (op_done && !ev.out_valid) begin
                pending <= 1'b1;
                lat_cnt <= LW'(1);
            end else if (ev.out_valid || lat_hit) begin
                pending <= 1'b0;
                lat_cnt <= '0;
            end else if (pending) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (viol_d) begin
            rsp_rule  <= rule_d;
            rsp_stamp <= ev.stamp;
        end
    end

    // The latency timer only counts for an operation that still waits for out_valid
    a_timer_pending: assert property (@(posedge clk) disable iff (!inf)
        (lat_cnt != '0) |-> pending);

endmodule

// File: rule_check/sequence_check.sv
// Step order and gap checker
`timescale 1ns/1ps

module sequence_check import bev_mon_pkg::*; #(
    parameter int GAP_MAX = 4
) (
    input  logic   clk,
    input  logic   inf,
    mon_event_if.seq ev,
    output logic   op_done,
    output logic   seq_viol,
    output rule_t  seq_rule,
    output stamp_t seq_stamp
);

    localparam int GW = $clog2(GAP_MAX + 1);

    // Each state names the step that must come next
    typedef enum logic [2:0] {
        st_idle,
        st_type,
        st_size,
        st_date,
        st_box_no,
        st_box_sup
    } seq_state_t;

    seq_state_t    state;
    action_t       act_q;
    box_cnt_t      box_cnt;
    logic [GW-1:0] gap_cnt;
    step_t         exp_step;
    logic          has_step;
    logic          step_err;
    logic          gap_hit;
    logic          last_step;
    logic          viol_d;
    rule_t         rule_d;

    always_comb begin
        case (state)
            st_type:    exp_step = step_bev_type;
            st_size:    exp_step = step_bev_size;
            st_date:    exp_step = step_date;
            st_box_no:  exp_step = step_box_no;
            st_box_sup: exp_step = step_box_sup;
            default:    exp_step = step_sel_action;
        endcase
    end

    assign has_step = ev.step != step_none;
    assign step_err = has_step && (ev.step != exp_step);
    // gap_cnt holds the silent cycles seen so far, so this is silence number GAP_MAX+1
    assign gap_hit  = (state != st_idle) && !has_step && (gap_cnt == GW'(GAP_MAX));
    assign last_step = has_step && !step_err &&
                       ((state == st_box_no && act_q != supply) ||
                        (state == st_box_sup && box_cnt == box_cnt_t'(SUPPLY_BOXES - 1)));

    // One record per cycle, in rule code order
    always_comb begin
        viol_d = 1'b1;
        rule_d = rule_overlap;
        if (ev.multi) begin
            rule_d = rule_overlap;
        end else if (step_err) begin
            rule_d = rule_order;
        end else if (gap_hit) begin
            rule_d = rule_gap;
        end else if (ev.step == step_date && !ev.date_ok) begin
            rule_d = rule_date;
        end else begin
            viol_d = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state    <= st_idle;
            act_q    <= make_drink;
            box_cnt  <= '0;
            gap_cnt  <= '0;
            op_done  <= 1'b0;
            seq_viol <= 1'b0;
        end else begin
            op_done  <= last_step;
            seq_viol <= viol_d;
            if (has_step || state == st_idle || gap_hit) begin
                gap_cnt <= '0;
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
            // A wrong step or a silence abandons the operation
            if (step_err || gap_hit) begin
                state   <= st_idle;
                box_cnt <= '0;
            end else if (has_step) begin
                case (state)
                    st_idle: begin
                        act_q <= ev.act;
                        state <= (ev.act == make_drink) ? st_type : st_date;
                    end
                    st_type:   state <= st_size;
                    st_size:   state <= st_date;
                    st_date:   state <= st_box_no;
                    st_box_no: state <= (act_q == supply) ? st_box_sup : st_idle;
                    st_box_sup: begin
                        if (last_step) begin
                            state   <= st_idle;
                            box_cnt <= '0;
                        end else begin
                            box_cnt <= box_cnt + 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // The event stamp of a gap hit already equals the previous step plus GAP_MAX+1
    always_ff @(posedge clk) begin
        if (viol_d) begin
            seq_rule  <= rule_d;
            seq_stamp <= ev.stamp;
        end
    end

    // Boxes are only counted inside a supply operation, and never reach the limit
    a_box_cnt: assert property (@(posedge clk) disable iff (!inf)
        (box_cnt != '0) |-> (state == st_box_sup && box_cnt < box_cnt_t'(SUPPLY_BOXES)));

endmodule

// File: testbench/bev_monitor_golden.txt
// kind a b: 1 inputs b at cycle a, 2 report rule a stamp b, 3 credit hold b from cycle a, 4 lost b
// inputs: [31:28] c_out c_in complete out_valid [27:24] err [23:16] day [15:12] month [11:8] action [7:0] strobes
// Clean make_drink, supply and check_date, the last one on 12/31
1 04 00000020
1 05 00000010
1 06 00000008
1 07 000f3004
1 08 00000002
1 0a 10000000
1 0c 00000120
1 0d 000f3004
1 0e 00000002
1 0f 00000001
1 10 00000001
1 11 00000001
1 12 00000001
1 14 10000000
1 16 00000220
1 17 001fc004
1 18 00000002
1 1a 10000000
// Overlap, order and gap
1 1e 00000030
2 0 001e
1 21 00000020
1 22 00000008
2 1 0022
1 26 00000020
1 27 00000010
2 2 002c
// Dates 2/29, 4/31 and 13/1
1 30 00000220
1 31 001d2004
2 3 0031
1 32 00000002
1 34 10000000
1 38 00000220
1 39 001f4004
2 3 0039
1 3a 00000002
1 3c 10000000
1 40 00000220
1 41 0001d004
2 3 0041
1 42 00000002
1 44 10000000
// Missing out_valid, complete with ing_of, bridge repeats, long out_valid
1 48 00000020
1 49 00000010
1 4a 00000008
1 4b 000f3004
1 4c 00000002
1 50 23000000
2 6 0050
1 54 40000000
1 55 40000000
2 7 0055
1 58 80000000
1 5a 40000000
1 5c 40000000
2 7 005c
1 5e 80000000
2 4 0075
1 78 10000000
1 79 10000000
2 5 0079
// Credits withheld, then a burst of seven overlaps where the last one is dropped
3 8c 1
1 90 00000030
1 91 00000030
1 92 00000030
1 93 00000030
1 94 00000030
1 95 00000030
1 96 00000030
2 0 0090
2 0 0091
2 0 0092
2 0 0093
2 0 0094
2 0 0095
4 97 0
4 98 1
3 a0 0
0 0 0

// File: testbench/bev_monitor_tb.sv
// Beverage monitor testbench
`timescale 1ns/1ps

module bev_monitor_tb import bev_mon_pkg::*;;

    // Short latency limit keeps the missing out_valid case brief
    localparam int LATENCY_MAX    = 40;
    localparam int REPORT_CREDITS = 2;
    localparam int GOLDEN_WORDS   = 384;

    logic    clk;
    logic    inf;
    logic    sel_action_valid;
    logic    type_valid;
    logic    size_valid;
    logic    date_valid;
    logic    box_no_valid;
    logic    box_sup_valid;
    action_t action;
    month_t  month;
    day_t    day;
    logic    out_valid;
    logic    complete;
    err_t    err_msg;
    logic    c_in_valid;
    logic    c_out_valid;
    logic    credit_return;
    logic    report_valid;
    rule_t   report_rule;
    stamp_t  report_stamp;
    logic    report_lost;

    // Golden file contents, three words per line
    logic [31:0] golden_mem [GOLDEN_WORDS];
    int          stim_cycle [$];
    logic [31:0] stim_data  [$];
    int          ctrl_cycle [$];
    int          ctrl_kind  [$];
    logic [31:0] ctrl_value [$];
    rule_t       exp_rule   [$];
    stamp_t      exp_stamp  [$];

    int          cycle;
    int          last_cycle;
    int          limit;
    int          drain;
    int          stim_idx;
    int          ctrl_idx;
    int          exp_idx;
    // Credits taken by reports and not yet handed back
    int          owed;
    logic        hold;
    logic [31:0] rnd;
    int          value_errors;
    int          other_errors;
    logic        finished;
    logic        timed_out;

    tb_clock u_tb_clock (
        .clk (clk),
        .inf (inf)
    );

    bev_monitor_top #(
        .LATENCY_MAX    (LATENCY_MAX),
        .REPORT_CREDITS (REPORT_CREDITS)
    ) u_bev_monitor_top (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .action           (action),
        .month            (month),
        .day              (day),
        .out_valid        (out_valid),
        .complete         (complete),
        .err_msg          (err_msg),
        .c_in_valid       (c_in_valid),
        .c_out_valid      (c_out_valid),
        .credit_return    (credit_return),
        .report_valid     (report_valid),
        .report_rule      (report_rule),
        .report_stamp     (report_stamp),
        .report_lost      (report_lost)
    );

    // Xorshift step for the credit return times
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string rule_name(input rule_t r);
        case (r)
            rule_overlap:  return "overlap";
            rule_order:    return "order";
            rule_gap:      return "gap";
            rule_date:     return "date";
            rule_latency:  return "latency";
            rule_pulse:    return "pulse";
            rule_complete: return "complete";
            rule_bridge:   return "bridge";
            default:       return "unknown";
        endcase
    endfunction

    // Splits the golden lines into stimulus, control and expected reports
    task automatic load_golden();
        int          i;
        logic [31:0] kind;
        logic [31:0] a;
        logic [31:0] b;
        logic        ended;
        i = 0;
        ended = 1'b0;
        last_cycle = 0;
        $readmemh("testbench/bev_monitor_golden.txt", golden_mem);
        while (!ended && i + 2 < GOLDEN_WORDS) begin
            kind = golden_mem[i];
            a = golden_mem[i + 1];
            b = golden_mem[i + 2];
            if ($isunknown(kind) || kind == 32'd0) begin
                ended = 1'b1;
            end else begin
                case (kind)
                    32'd1: begin
                        stim_cycle.push_back(int'(a));
                        stim_data.push_back(b);
                    end
                    32'd2: begin
                        exp_rule.push_back(rule_t'(a[3:0]));
                        exp_stamp.push_back(b[15:0]);
                    end
                    32'd3, 32'd4: begin
                        ctrl_cycle.push_back(int'(a));
                        ctrl_kind.push_back(int'(kind));
                        ctrl_value.push_back(b);
                    end
                    default: begin
                        $display("Golden file line %0d has an unknown kind %0d", i / 3, kind);
                        other_errors++;
                    end
                endcase
                // Expected reports carry a rule, not a cycle
                if (kind != 32'd2 && int'(a) > last_cycle) begin
                    last_cycle = int'(a);
                end
                i += 3;
            end
        end
    endtask

    // Sets every input for the next rising edge, idle unless a stimulus line names it
    task automatic drive_inputs(input int next_cycle);
        logic [31:0] d;
        d = '0;
        if (stim_idx < stim_cycle.size() && stim_cycle[stim_idx] == next_cycle) begin
            d = stim_data[stim_idx];
            stim_idx++;
        end
        box_sup_valid    = d[0];
        box_no_valid     = d[1];
        date_valid       = d[2];
        size_valid       = d[3];
        type_valid       = d[4];
        sel_action_valid = d[5];
        action           = action_t'(d[9:8]);
        month            = d[15:12];
        day              = d[20:16];
        err_msg          = err_t'(d[25:24]);
        out_valid        = d[28];
        complete         = d[29];
        c_in_valid       = d[30];
        c_out_valid      = d[31];
        // At most one credit per cycle, and never one that was not spent
        rnd = next_random(rnd);
        if (!hold && owed > 0 && rnd[0]) begin
            credit_return = 1'b1;
            owed--;
        end else begin
            credit_return = 1'b0;
        end
    endtask

    // Reports are matched in order against the expected list
    task automatic check_report();
        string name;
        if (report_valid === 1'b1) begin
            // credit_return still shows the credit handed back at this edge,
            // so the sum is what was outstanding one edge earlier
            if (owed + int'(credit_return) >= REPORT_CREDITS) begin
                $display("Report at cycle %0d was sent while no credit was left", cycle);
                other_errors++;
            end
            owed++;
            if (exp_idx >= exp_rule.size()) begin
                $display("Unexpected report with rule %0d and stamp %h after the last expected one",
                         report_rule, report_stamp);
                other_errors++;
            end else begin
                name = $sformatf("report %0d %s", exp_idx, rule_name(exp_rule[exp_idx]));
                if (report_rule !== exp_rule[exp_idx]) begin
                    $display("[ERROR] %s rule: expected %0d, actual %0d",
                             name, exp_rule[exp_idx], report_rule);
                    value_errors++;
                end
                if (report_stamp !== exp_stamp[exp_idx]) begin
                    $display("[ERROR] %s stamp: expected %h, actual %h",
                             name, exp_stamp[exp_idx], report_stamp);
                    value_errors++;
                end
                exp_idx++;
            end
        end
    endtask

    // Credit hold windows and report_lost checks that fall due this cycle
    task automatic apply_controls();
        logic v;
        while (ctrl_idx < ctrl_cycle.size() && ctrl_cycle[ctrl_idx] <= cycle) begin
            v = ctrl_value[ctrl_idx][0];
            if (ctrl_kind[ctrl_idx] == 3) begin
                hold = v;
            end else if (report_lost !== v) begin
                $display("[ERROR] report_lost at cycle %0d: expected %0d, actual %0d",
                         cycle, v, report_lost);
                value_errors++;
            end
            ctrl_idx++;
        end
    endtask

    initial begin
        sel_action_valid = 1'b0;
        type_valid       = 1'b0;
        size_valid       = 1'b0;
        date_valid       = 1'b0;
        box_no_valid     = 1'b0;
        box_sup_valid    = 1'b0;
        action           = make_drink;
        month            = '0;
        day              = '0;
        out_valid        = 1'b0;
        complete         = 1'b0;
        err_msg          = no_err;
        c_in_valid       = 1'b0;
        c_out_valid      = 1'b0;
        credit_return    = 1'b0;
        cycle            = 0;
        stim_idx         = 0;
        ctrl_idx         = 0;
        exp_idx          = 0;
        owed             = 0;
        hold             = 1'b0;
        rnd              = 32'hbcfa_2003;
        value_errors     = 0;
        other_errors     = 0;
        finished         = 1'b0;
        timed_out        = 1'b0;
        load_golden();
        if (stim_cycle.size() == 0 || exp_rule.size() == 0) begin
            $display("The golden file gave no stimulus or no expected reports");
            other_errors++;
        end
        limit = last_cycle + LATENCY_MAX + 200;
        // Quiet tail that would catch a late latency report
        drain = last_cycle + LATENCY_MAX + 8;
        // Reset lifts 1 ns after an edge, so the inputs for edge 1 go out now
        wait (inf === 1'b1);
        drive_inputs(1);
        while (!finished && !timed_out) begin
            @(posedge clk);
            #1;
            cycle++;
            check_report();
            apply_controls();
            drive_inputs(cycle + 1);
            if (exp_idx == exp_rule.size() && cycle >= drain) begin
                finished = 1'b1;
            end else if (cycle >= limit) begin
                $display("Timeout at cycle %0d with %0d of %0d expected reports seen",
                         cycle, exp_idx, exp_rule.size());
                other_errors++;
                timed_out = 1'b1;
            end
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors != 0 || other_errors != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic inf
);

    // Free running clock with a 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset stays low over the first two rising edges and lifts just after the second
    initial begin
        inf = 1'b0;
        repeat (2) @(posedge clk);
        #1 inf = 1'b1;
    end

endmodule

// File: verilog.f
common/bev_mon_pkg.sv
common/mon_event_if.sv
verilog/event_capture.sv
rule_check/sequence_check.sv
rule_check/response_check.sv
report/report_sender.sv
verilog/bev_monitor_top.sv
testbench/tb_clock.sv
testbench/bev_monitor_tb.sv

// File: verilog/bev_monitor_top.sv
// Beverage protocol monitor
`timescale 1ns/1ps

module bev_monitor_top import bev_mon_pkg::*; #(
    parameter int GAP_MAX        = 4,
    parameter int LATENCY_MAX    = 1000,
    parameter int REPORT_DEPTH   = 4,
    parameter int REPORT_CREDITS = 2
) (
    input  logic    clk,
    input  logic    inf,
    input  logic    sel_action_valid,
    input  logic    type_valid,
    input  logic    size_valid,
    input  logic    date_valid,
    input  logic    box_no_valid,
    input  logic    box_sup_valid,
    input  action_t action,
    input  month_t  month,
    input  day_t    day,
    input  logic    out_valid,
    input  logic    complete,
    input  err_t    err_msg,
    input  logic    c_in_valid,
    input  logic    c_out_valid,
    input  logic    credit_return,
    output logic    report_valid,
    output rule_t   report_rule,
    output stamp_t  report_stamp,
    output logic    report_lost
);

    logic   op_done;
    logic   seq_viol;
    rule_t  seq_rule;
    stamp_t seq_stamp;
    logic   rsp_viol;
    rule_t  rsp_rule;
    stamp_t rsp_stamp;

    mon_event_if u_ev ();

    event_capture u_event_capture (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .action           (action),
        .month            (month),
        .day              (day),
        .out_valid        (out_valid),
        .complete         (complete),
        .err_msg          (err_msg),
        .c_in_valid       (c_in_valid),
        .c_out_valid      (c_out_valid),
        .ev               (u_ev)
    );

    sequence_check #(
        .GAP_MAX (GAP_MAX)
    ) u_sequence_check (
        .clk       (clk),
        .inf       (inf),
        .ev        (u_ev),
        .op_done   (op_done),
        .seq_viol  (seq_viol),
        .seq_rule  (seq_rule),
        .seq_stamp (seq_stamp)
    );

    response_check #(
        .LATENCY_MAX (LATENCY_MAX)
    ) u_response_check (
        .clk       (clk),
        .inf       (inf),
        .op_done   (op_done),
        .ev        (u_ev),
        .rsp_viol  (rsp_viol),
        .rsp_rule  (rsp_rule),
        .rsp_stamp (rsp_stamp)
    );

    report_sender #(
        .REPORT_DEPTH   (REPORT_DEPTH),
        .REPORT_CREDITS (REPORT_CREDITS)
    ) u_report_sender (
        .clk           (clk),
        .inf           (inf),
        .seq_viol      (seq_viol),
        .seq_rule      (seq_rule),
        .seq_stamp     (seq_stamp),
        .rsp_viol      (rsp_viol),
        .rsp_rule      (rsp_rule),
        .rsp_stamp     (rsp_stamp),
        .credit_return (credit_return),
        .report_valid  (report_valid),
        .report_rule   (report_rule),
        .report_stamp  (report_stamp),
        .report_lost   (report_lost)
    );

endmodule

// File: verilog/event_capture.sv
// Input event capture
`timescale 1ns/1ps

module event_capture import bev_mon_pkg::*; (
    input  logic    clk,
    input  logic    inf,
    input  logic    sel_action_valid,
    input  logic    type_valid,
    input  logic    size_valid,
    input  logic    date_valid,
    input  logic    box_no_valid,
    input  logic    box_sup_valid,
    input  action_t action,
    input  month_t  month,
    input  day_t    day,
    input  logic    out_valid,
    input  logic    complete,
    input  err_t    err_msg,
    input  logic    c_in_valid,
    input  logic    c_out_valid,
    mon_event_if.capture ev
);

    logic [5:0] strobes;
    step_t      step_d;
    day_t       days;

    assign strobes = {sel_action_valid, type_valid, size_valid,
                      date_valid, box_no_valid, box_sup_valid};
    assign days    = days_in_month(month);

    // Only a lone strobe names a step, overlapping strobes decode to none
    always_comb begin
        case (strobes)
            6'b100000: step_d = step_sel_action;
            6'b010000: step_d = step_bev_type;
            6'b001000: step_d = step_bev_size;
            6'b000100: step_d = step_date;
            6'b000010: step_d = step_box_no;
            6'b000001: step_d = step_box_sup;
            default:   step_d = step_none;
        endcase
    end

    // Strobes and the stamp counter
    // The stamp register doubles as the edge counter, so after edge N it reads N
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            ev.step      <= step_none;
            ev.multi     <= 1'b0;
            ev.stamp     <= '0;
            ev.out_valid <= 1'b0;
            ev.complete  <= 1'b0;
            ev.c_in      <= 1'b0;
            ev.c_out     <= 1'b0;
        end else begin
            ev.step      <= step_d;
            ev.multi     <= !$onehot0(strobes);
            ev.stamp     <= ev.stamp + 1'b1;
            ev.out_valid <= out_valid;
            ev.complete  <= complete;
            ev.c_in      <= c_in_valid;
            ev.c_out     <= c_out_valid;
        end
    end

    // Data that is only looked at together with a strobe
    always_ff @(posedge clk) begin
        ev.act     <= action;
        ev.err     <= err_msg;
        // Day 0 never exists, and an unknown month gives zero days
        ev.date_ok <= (day != '0) && (day <= days);
    end

endmodule
